// File: Bender.yml
package:
  name: dma_wh_bridge

sources:
  - dma_wh_pkg.sv
  - dma_wh_tx.sv
  - dma_wh_return_buf.sv
  - dma_wh_rx.sv
  - dma_wh_bridge.sv
  - target: test
    files:
      - tb_dma_wh_mem_model.sv
      - tb_dma_wh_bridge.sv

// File: dma_wh_bridge.f
dma_wh_pkg.sv
dma_wh_tx.sv
dma_wh_return_buf.sv
dma_wh_rx.sv
dma_wh_bridge.sv
tb_dma_wh_mem_model.sv
tb_dma_wh_bridge.sv

// File: dma_wh_bridge.sv
`timescale 1ns/1ps

module dma_wh_bridge (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // cache dma side
  input  dma_wh_pkg::dma_pkt_t          dma_pkt_i,
  input  logic                          dma_pkt_v_i,
  output logic                          dma_pkt_yumi_o,
  input  logic [dma_wh_pkg::FLIT_W-1:0] dma_wdata_i,
  input  logic                          dma_wdata_v_i,
  output logic                          dma_wdata_yumi_o,
  output logic [dma_wh_pkg::FLIT_W-1:0] dma_rdata_o,
  output logic                          dma_rdata_v_o,
  input  logic                          dma_rdata_ready_i,
  // outgoing link
  output dma_wh_pkg::flit_t             link_flit_o,
  output logic                          link_flit_v_o,
  input  logic                          link_credit_i,
  // incoming link
  input  dma_wh_pkg::flit_t             link_flit_i,
  input  logic                          link_flit_v_i,
  output logic                          link_credit_o,
  // static configuration
  input  logic [dma_wh_pkg::CORD_W-1:0] my_cord_i,
  input  logic [dma_wh_pkg::CID_W-1:0]  my_cid_i,
  input  logic [dma_wh_pkg::CORD_W-1:0] dest_cord_i,
  input  logic [dma_wh_pkg::CID_W-1:0]  dest_cid_i
);
  import dma_wh_pkg::*;

  flit_t buf_flit;
  logic  buf_v;
  logic  buf_pop;

  dma_wh_tx dma_wh_tx_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dma_pkt_i        (dma_pkt_i),
    .dma_pkt_v_i      (dma_pkt_v_i),
    .dma_pkt_yumi_o   (dma_pkt_yumi_o),
    .dma_wdata_i      (dma_wdata_i),
    .dma_wdata_v_i    (dma_wdata_v_i),
    .dma_wdata_yumi_o (dma_wdata_yumi_o),
    .link_flit_o      (link_flit_o),
    .link_flit_v_o    (link_flit_v_o),
    .link_credit_i    (link_credit_i),
    .my_cord_i        (my_cord_i),
    .my_cid_i         (my_cid_i),
    .dest_cord_i      (dest_cord_i),
    .dest_cid_i       (dest_cid_i)
  );

  // every incoming flit lands here first
  dma_wh_return_buf dma_wh_return_buf_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flit_i   (link_flit_i),
    .flit_v_i (link_flit_v_i),
    .pop_i    (buf_pop),
    .flit_o   (buf_flit),
    .flit_v_o (buf_v),
    .credit_o (link_credit_o)
  );

  dma_wh_rx dma_wh_rx_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .buf_flit_i        (buf_flit),
    .buf_v_i           (buf_v),
    .dma_rdata_ready_i (dma_rdata_ready_i),
    .buf_pop_o         (buf_pop),
    .dma_rdata_o       (dma_rdata_o),
    .dma_rdata_v_o     (dma_rdata_v_o)
  );

endmodule

// File: dma_wh_pkg.sv
package dma_wh_pkg;

  // link and dma sizes
  localparam int FLIT_W = 64;
  localparam int ADDR_W = 32;
  localparam int BURST_LEN = 4;

  // wormhole header field widths
  localparam int CORD_W = 8;
  localparam int CID_W = 4;
  // must be able to hold BURST_LEN+1
  localparam int LEN_W = 4;

  // far side buffer depth seen by the outgoing link
  localparam int LINK_CREDITS = 4;
  // local return buffer depth, also the credits granted to the far side
  localparam int RETURN_DEPTH = 4;

  // dma packet queue in front of the send FSM
  localparam int PKT_Q_DEPTH = 2;

  // derived widths
  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam int CREDIT_W = $clog2(LINK_CREDITS + 1);
  localparam int RET_PTR_W = $clog2(RETURN_DEPTH);
  localparam int RET_CNT_W = $clog2(RETURN_DEPTH + 1);
  localparam int PKT_CNT_W = $clog2(PKT_Q_DEPTH + 1);

  // header padding fills the flit above the real fields
  localparam int HDR_PAD_W = FLIT_W - 1 - 2 * CID_W - 2 * CORD_W - LEN_W;

  // request from the cache
  typedef struct packed {
    logic              write_not_read;
    logic [ADDR_W-1:0] addr;
  } dma_pkt_t;

  // first flit of every packet on the link
  typedef struct packed {
    logic [HDR_PAD_W-1:0] unused;
    logic                 write_not_read;
    logic [CID_W-1:0]     src_cid;
    logic [CORD_W-1:0]    src_cord;
    // flits following the header
    logic [LEN_W-1:0]     len;
    logic [CORD_W-1:0]    cord;
    logic [CID_W-1:0]     cid;
  } wh_header_t;

  // one link beat, last marks the tail of a packet
  typedef struct packed {
    logic [FLIT_W-1:0] data;
    logic              last;
  } flit_t;

  // send FSM
  // idle is only passed once after reset
  typedef enum logic [1:0] {
    SEND_IDLE,
    SEND_HDR,
    SEND_ADDR,
    SEND_DATA
  } send_state_e;

  // receive FSM
  typedef enum logic {
    RECV_HDR,
    RECV_DATA
  } recv_state_e;

endpackage

// File: dma_wh_return_buf.sv
`timescale 1ns/1ps

module dma_wh_return_buf (
  input  logic              clk_i,
  input  logic              reset_i,
  input  dma_wh_pkg::flit_t flit_i,
  input  logic              flit_v_i,
  input  logic              pop_i,
  output dma_wh_pkg::flit_t flit_o,
  output logic              flit_v_o,
  output logic              credit_o
);
  import dma_wh_pkg::*;

  flit_t                mem [RETURN_DEPTH];
  logic [RET_PTR_W-1:0] wr_ptr;
  logic [RET_PTR_W-1:0] rd_ptr;
  logic [RET_CNT_W-1:0] cnt;
  logic                 full;

  assign full     = (cnt == RET_CNT_W'(RETURN_DEPTH));
  assign flit_v_o = (cnt != '0);
  assign flit_o   = mem[rd_ptr];

  // far side only sends with a credit, so no full check on push
  always_ff @(posedge clk_i) begin
    if (flit_v_i) begin
      mem[wr_ptr] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      cnt      <= '0;
      credit_o <= 1'b0;
    end else begin
      if (flit_v_i) begin
        wr_ptr <= (wr_ptr == RET_PTR_W'(RETURN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == RET_PTR_W'(RETURN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      cnt <= cnt + RET_CNT_W'(flit_v_i) - RET_CNT_W'(pop_i);
      // one slot freed, one credit back a cycle later
      credit_o <= pop_i;
    end
  end

  // a full buffer means every credit is out, so the link must be quiet
  a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
    flit_v_i |-> !full)
    else $error("return buffer written while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> flit_v_o)
    else $error("return buffer popped while empty");

endmodule

// File: dma_wh_rx.sv
`timescale 1ns/1ps

module dma_wh_rx (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  dma_wh_pkg::flit_t             buf_flit_i,
  input  logic                          buf_v_i,
  input  logic                          dma_rdata_ready_i,
  output logic                          buf_pop_o,
  output logic [dma_wh_pkg::FLIT_W-1:0] dma_rdata_o,
  output logic                          dma_rdata_v_o
);
  import dma_wh_pkg::*;

  recv_state_e       state_r;
  recv_state_e       state_n;
  logic [BEAT_W-1:0] beat_r;
  logic [BEAT_W-1:0] beat_n;
  logic              beat_last;

  assign beat_last = (beat_r == BEAT_W'(BURST_LEN - 1));

  always_comb begin
    state_n       = state_r;
    beat_n        = beat_r;
    buf_pop_o     = 1'b0;
    dma_rdata_v_o = 1'b0;
    // fill data straight from the buffer head
    dma_rdata_o   = buf_flit_i.data;
    case (state_r)
      RECV_HDR: begin
        // returned header is dropped, the cache never sees it
        buf_pop_o = buf_v_i;
        if (buf_v_i) begin
          state_n = RECV_DATA;
        end
      end
      RECV_DATA: begin
        dma_rdata_v_o = buf_v_i;
        buf_pop_o     = buf_v_i & dma_rdata_ready_i;
        if (buf_pop_o) begin
          if (beat_last) begin
            beat_n  = '0;
            state_n = RECV_HDR;
          end else begin
            beat_n = beat_r + 1'b1;
          end
        end
      end
      default: begin
        state_n = RECV_HDR;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RECV_HDR;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      beat_r  <= beat_n;
    end
  end

  // tail marking from the far side must agree with the local beat count
  a_last_on_final_beat: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == RECV_DATA && buf_pop_o) |-> (buf_flit_i.last == beat_last))
    else $error("fill flit last bit does not match beat %0d", beat_r);

endmodule

// File: dma_wh_tx.sv
`timescale 1ns/1ps

module dma_wh_tx (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  dma_wh_pkg::dma_pkt_t          dma_pkt_i,
  input  logic                          dma_pkt_v_i,
  output logic                          dma_pkt_yumi_o,
  input  logic [dma_wh_pkg::FLIT_W-1:0] dma_wdata_i,
  input  logic                          dma_wdata_v_i,
  output logic                          dma_wdata_yumi_o,
  output dma_wh_pkg::flit_t             link_flit_o,
  output logic                          link_flit_v_o,
  input  logic                          link_credit_i,
  input  logic [dma_wh_pkg::CORD_W-1:0] my_cord_i,
  input  logic [dma_wh_pkg::CID_W-1:0]  my_cid_i,
  input  logic [dma_wh_pkg::CORD_W-1:0] dest_cord_i,
  input  logic [dma_wh_pkg::CID_W-1:0]  dest_cid_i
);
  import dma_wh_pkg::*;

  // packet queue, two entries so a writeback and a fill go out back to back
  dma_pkt_t             pkt_q [PKT_Q_DEPTH];
  logic                 q_wr_ptr;
  logic                 q_rd_ptr;
  logic [PKT_CNT_W-1:0] q_cnt;
  logic                 q_push;
  logic                 q_pop;
  dma_pkt_t             head_pkt;
  logic                 head_v;

  send_state_e          state_r;
  send_state_e          state_n;
  logic [BEAT_W-1:0]    beat_r;
  logic [BEAT_W-1:0]    beat_n;
  logic [CREDIT_W-1:0]  credit_r;
  logic                 credit_ok;
  logic                 beat_last;
  wh_header_t           hdr;

  assign q_push = dma_pkt_v_i & (q_cnt != PKT_CNT_W'(PKT_Q_DEPTH));
  assign dma_pkt_yumi_o = q_push;
  assign head_pkt = pkt_q[q_rd_ptr];
  assign head_v = (q_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (q_push) begin
      pkt_q[q_wr_ptr] <= dma_pkt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
      q_cnt    <= '0;
    end else begin
      if (q_push) begin
        q_wr_ptr <= ~q_wr_ptr;
      end
      if (q_pop) begin
        q_rd_ptr <= ~q_rd_ptr;
      end
      q_cnt <= q_cnt + PKT_CNT_W'(q_push) - PKT_CNT_W'(q_pop);
    end
  end

  // header for the packet at the queue head
  always_comb begin
    hdr                = '0;
    hdr.write_not_read = head_pkt.write_not_read;
    hdr.src_cid        = my_cid_i;
    hdr.src_cord       = my_cord_i;
    // write carries addr plus the burst, read only the addr
    hdr.len            = head_pkt.write_not_read ? LEN_W'(BURST_LEN + 1) : LEN_W'(1);
    hdr.cord           = dest_cord_i;
    hdr.cid            = dest_cid_i;
  end

  assign credit_ok = (credit_r != '0);
  assign beat_last = (beat_r == BEAT_W'(BURST_LEN - 1));

  always_comb begin
    state_n          = state_r;
    beat_n           = beat_r;
    q_pop            = 1'b0;
    link_flit_v_o    = 1'b0;
    dma_wdata_yumi_o = 1'b0;
    link_flit_o.data = dma_wdata_i;
    link_flit_o.last = 1'b0;
    case (state_r)
      SEND_IDLE: begin
        state_n = SEND_HDR;
      end
      SEND_HDR: begin
        link_flit_o.data = hdr;
        if (head_v && credit_ok) begin
          link_flit_v_o = 1'b1;
          state_n       = SEND_ADDR;
        end
      end
      SEND_ADDR: begin
        link_flit_o.data = FLIT_W'(head_pkt.addr);
        // a read ends with its address flit
        link_flit_o.last = ~head_pkt.write_not_read;
        if (credit_ok) begin
          link_flit_v_o = 1'b1;
          q_pop         = 1'b1;
          state_n       = head_pkt.write_not_read ? SEND_DATA : SEND_HDR;
        end
      end
      SEND_DATA: begin
        link_flit_o.last = beat_last;
        if (credit_ok && dma_wdata_v_i) begin
          link_flit_v_o    = 1'b1;
          dma_wdata_yumi_o = 1'b1;
          if (beat_last) begin
            beat_n  = '0;
            state_n = SEND_HDR;
          end else begin
            beat_n = beat_r + 1'b1;
          end
        end
      end
      default: begin
        state_n = SEND_HDR;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= SEND_IDLE;
      beat_r   <= '0;
      credit_r <= CREDIT_W'(LINK_CREDITS);
    end else begin
      state_r  <= state_n;
      beat_r   <= beat_n;
      // return and spend may land in the same cycle
      credit_r <= credit_r + CREDIT_W'(link_credit_i) - CREDIT_W'(link_flit_v_o);
    end
  end

  // far side never frees more slots than it owns
  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_r <= CREDIT_W'(LINK_CREDITS))
    else $error("tx credit count above LINK_CREDITS");

  a_send_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    link_flit_v_o |-> (credit_r != '0))
    else $error("flit sent without a credit");

endmodule

// File: tb_dma_wh_bridge.sv
`timescale 1ns/1ps

module tb_dma_wh_bridge;
  import dma_wh_pkg::*;

  localparam logic [CORD_W-1:0] MY_CORD   = 8'h21;
  localparam logic [CID_W-1:0]  MY_CID    = 4'h3;
  localparam logic [CORD_W-1:0] DEST_CORD = 8'h05;
  localparam logic [CID_W-1:0]  DEST_CID  = 4'h9;
  localparam logic [FLIT_W-1:0] FILL_K    = 64'h9e3779b97f4a7c15;
  localparam int NUM_PKTS = 30;
  localparam int TIMEOUT_CYCLES = 200 * NUM_PKTS;

  logic clk_i = 1'b0;
  logic reset_i;
  dma_pkt_t dma_pkt_i;
  logic dma_pkt_v_i, dma_pkt_yumi_o;
  logic [FLIT_W-1:0] dma_wdata_i, dma_rdata_o;
  logic dma_wdata_v_i, dma_wdata_yumi_o, dma_rdata_v_o, dma_rdata_ready_i;
  flit_t link_flit_o, ret_flit;
  logic link_flit_v_o, link_credit_i, ret_flit_v, link_credit_o;
  int credit_delay_max, ready_random;

  flit_t exp_flit_q [$];
  logic [FLIT_W-1:0] exp_rdata_q [$];
  logic [FLIT_W-1:0] wdata_q [$];
  logic [FLIT_W-1:0] ref_store [logic [ADDR_W+BEAT_W-1:0]];
  int cycles = 0, errors = 0, test_errors, tests_run = 0, tests_ok = 0;
  int outstanding = 0, far_credits = RETURN_DEPTH, ret_flits = 0, credit_pulses = 0;

  always #4 clk_i = ~clk_i;

  dma_wh_bridge dma_wh_bridge_inst (
    .clk_i, .reset_i, .dma_pkt_i, .dma_pkt_v_i, .dma_pkt_yumi_o,
    .dma_wdata_i, .dma_wdata_v_i, .dma_wdata_yumi_o,
    .dma_rdata_o, .dma_rdata_v_o, .dma_rdata_ready_i,
    .link_flit_o, .link_flit_v_o, .link_credit_i,
    .link_flit_i (ret_flit), .link_flit_v_i (ret_flit_v), .link_credit_o,
    .my_cord_i (MY_CORD), .my_cid_i (MY_CID), .dest_cord_i (DEST_CORD), .dest_cid_i (DEST_CID)
  );

  tb_dma_wh_mem_model mem_model_inst (
    .clk_i, .reset_i, .link_flit_i (link_flit_o), .link_flit_v_i (link_flit_v_o),
    .link_credit_o (link_credit_i), .ret_flit_o (ret_flit), .ret_flit_v_o (ret_flit_v),
    .ret_credit_i (link_credit_o), .credit_delay_max_i (credit_delay_max)
  );

  task automatic check_value(input string name, input logic [FLIT_W-1:0] got,
                             input logic [FLIT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // header fields in link order, with len covering addr plus any burst
  function automatic flit_t expected_header(input dma_pkt_t p);
    flit_t f;
    f.data = {{(FLIT_W - 1 - 2 * CID_W - 2 * CORD_W - LEN_W){1'b0}}, p.write_not_read, MY_CID,
              MY_CORD, LEN_W'(p.write_not_read ? BURST_LEN + 1 : 1), DEST_CORD, DEST_CID};
    f.last = 1'b0;
    return f;
  endfunction

  function automatic logic [FLIT_W-1:0] expected_fill(input logic [ADDR_W-1:0] addr, input int b);
    if (ref_store.exists({addr, BEAT_W'(b)})) begin
      return ref_store[{addr, BEAT_W'(b)}];
    end
    return FLIT_W'(addr) ^ (FLIT_W'(b) * FILL_K);
  endfunction

  // called 1 ns after a rising edge and returns 1 ns after a later one
  task automatic issue_packet(input logic wnr, input logic [ADDR_W-1:0] addr,
                              output int accept_cycle);
    dma_pkt_t p;
    flit_t f;
    int b;
    p.write_not_read = wnr;
    p.addr = addr;
    exp_flit_q.push_back(expected_header(p));
    f.data = FLIT_W'(addr);
    f.last = ~wnr;
    exp_flit_q.push_back(f);
    for (b = 0; b < BURST_LEN; b++) begin
      if (wnr) begin
        f.data = {$urandom, $urandom};
        f.last = (b == BURST_LEN - 1);
        wdata_q.push_back(f.data);
        exp_flit_q.push_back(f);
        ref_store[{addr, BEAT_W'(b)}] = f.data;
      end else begin
        exp_rdata_q.push_back(expected_fill(addr, b));
      end
    end
    dma_pkt_i = p;
    dma_pkt_v_i = 1'b1;
    do @(negedge clk_i); while (!dma_pkt_yumi_o);
    accept_cycle = cycles;
    @(posedge clk_i);
    #1;
    dma_pkt_v_i = 1'b0;
  endtask

  task automatic drain_and_report(input string name);
    while (exp_flit_q.size() != 0 || exp_rdata_q.size() != 0) @(negedge clk_i);
    // last credit pulse trails the last pop by one cycle
    repeat (3) @(negedge clk_i);
    check_value("link_credit_o pulses", credit_pulses, ret_flits);
    tests_run++;
    if (errors == test_errors) tests_ok++;
    $display("test %s: %s", name, (errors == test_errors) ? "ok" : "errors seen");
    test_errors = errors;
    @(posedge clk_i);
    #1;
  endtask

  // write data source with random gaps
  always begin
    @(posedge clk_i);
    #1;
    dma_wdata_v_i = (wdata_q.size() != 0) && ($urandom_range(3, 0) != 0);
    dma_wdata_i = (wdata_q.size() != 0) ? wdata_q[0] : '0;
    dma_rdata_ready_i = ready_random ? 1'($urandom_range(1, 0)) : 1'b1;
    @(negedge clk_i);
    if (dma_wdata_yumi_o) void'(wdata_q.pop_front());
  end

  // compare link flits and fill beats against the expected queues
  always @(negedge clk_i) begin
    if (reset_i) begin
      check_value("reset outputs", {link_flit_v_o, dma_pkt_yumi_o, dma_wdata_yumi_o,
                                    dma_rdata_v_o, link_credit_o}, '0);
    end else begin
      if (link_flit_v_o) begin
        outstanding++;
        if (exp_flit_q.size() == 0) begin
          $display("unexpected flit on the outgoing link with nothing expected");
          errors++;
        end else begin
          check_value("link_flit_o.data", link_flit_o.data, exp_flit_q[0].data);
          check_value("link_flit_o.last", link_flit_o.last, exp_flit_q[0].last);
          void'(exp_flit_q.pop_front());
        end
      end
      check_value("outstanding within LINK_CREDITS", outstanding <= LINK_CREDITS, 1);
      if (link_credit_i) outstanding--;
      if (dma_rdata_v_o && dma_rdata_ready_i) begin
        if (exp_rdata_q.size() == 0) begin
          $display("fill beat delivered with no read outstanding");
          errors++;
        end else begin
          check_value("dma_rdata_o", dma_rdata_o, exp_rdata_q.pop_front());
        end
      end
      if (ret_flit_v) begin
        far_credits--;
        ret_flits++;
      end
      if (link_credit_o) begin
        far_credits++;
        credit_pulses++;
      end
      // a credit pulse with no consumed flit lets the far side overrun the buffer
      check_value("far side credits within RETURN_DEPTH", far_credits <= RETURN_DEPTH, 1);
    end
  end

  initial begin
    while (cycles <= TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [ADDR_W-1:0] a;
    int t0, t1, n;
    void'($urandom(32'h2eb84573));
    reset_i = 1'b1;
    dma_pkt_i = '0;
    dma_pkt_v_i = 1'b0;
    dma_wdata_i = '0;
    dma_wdata_v_i = 1'b0;
    dma_rdata_ready_i = 1'b1;
    credit_delay_max = 3;
    ready_random = 0;
    test_errors = 0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // first edge out of reset
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("post reset outputs", {link_flit_v_o, dma_pkt_yumi_o, dma_wdata_yumi_o,
                                       dma_rdata_v_o, link_credit_o}, '0);
    @(posedge clk_i);
    #1;
    drain_and_report("reset_state");

    issue_packet(1'b1, $urandom & 32'hffff_ffc0, t0);
    drain_and_report("write_format");
    issue_packet(1'b0, ($urandom & 32'h0fff_ffc0) | 32'h8000_0000, t0);
    drain_and_report("read_fill");

    a = $urandom & 32'hffff_ffc0;
    issue_packet(1'b1, a, t0);
    issue_packet(1'b0, a, t1);
    check_value("read accept cycle after write", t1 - t0, 1);
    drain_and_report("writeback_then_fill");

    credit_delay_max = 12;
    for (n = 0; n < 20; n++) begin
      issue_packet(1'($urandom_range(1, 0)), 32'h0001_0000 + 32'($urandom_range(15, 0)) * 64, t0);
    end
    drain_and_report("outgoing_credits");

    credit_delay_max = 3;
    ready_random = 1;
    for (n = 0; n < 6; n++) begin
      issue_packet(n == 2, 32'h0001_0000 + 32'($urandom_range(7, 0)) * 64, t0);
    end
    drain_and_report("fill_backpressure");

    $display("%0d tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb_dma_wh_mem_model.sv
`timescale 1ns/1ps

module tb_dma_wh_mem_model (
  input  logic              clk_i,
  input  logic              reset_i,
  input  dma_wh_pkg::flit_t link_flit_i,
  input  logic              link_flit_v_i,
  output logic              link_credit_o,
  output dma_wh_pkg::flit_t ret_flit_o,
  output logic              ret_flit_v_o,
  input  logic              ret_credit_i,
  input  int                credit_delay_max_i
);
  import dma_wh_pkg::*;

  localparam logic [FLIT_W-1:0] FILL_K = 64'h9e3779b97f4a7c15;

  logic [FLIT_W-1:0] store [logic [ADDR_W+BEAT_W-1:0]];
  flit_t             ret_q [$];
  int                credit_due_q [$];
  int                now;
  int                last_due;
  int                due;
  int                ret_credits;
  int                phase;
  int                beat;
  logic              in_reset;
  logic [ADDR_W-1:0] cur_addr;
  wh_header_t        rx_hdr;

  // header, address, then write data
  task automatic take_flit(input flit_t f);
    wh_header_t h;
    flit_t      r;
    int         b;
    case (phase)
      0: begin
        rx_hdr = f.data;
        phase  = 1;
      end
      1: begin
        cur_addr = f.data[ADDR_W-1:0];
        beat     = 0;
        phase    = rx_hdr.write_not_read ? 2 : 0;
        if (!rx_hdr.write_not_read) begin
          // reply goes back to the requester
          h          = '0;
          h.src_cid  = rx_hdr.cid;
          h.src_cord = rx_hdr.cord;
          h.len      = LEN_W'(BURST_LEN);
          h.cord     = rx_hdr.src_cord;
          h.cid      = rx_hdr.src_cid;
          r.data     = h;
          r.last     = 1'b0;
          ret_q.push_back(r);
          for (b = 0; b < BURST_LEN; b++) begin
            if (store.exists({cur_addr, BEAT_W'(b)})) begin
              r.data = store[{cur_addr, BEAT_W'(b)}];
            end else begin
              r.data = FLIT_W'(cur_addr) ^ (FLIT_W'(b) * FILL_K);
            end
            r.last = (b == BURST_LEN - 1);
            ret_q.push_back(r);
          end
        end
      end
      default: begin
        store[{cur_addr, BEAT_W'(beat)}] = f.data;
        beat++;
        if (beat == BURST_LEN) begin
          phase = 0;
        end
      end
    endcase
  endtask

  initial begin
    link_credit_o = 1'b0;
    ret_flit_v_o  = 1'b0;
    ret_flit_o    = '0;
    now           = 0;
    last_due      = 0;
    forever begin
      // sample at the falling edge where everything is settled
      @(negedge clk_i);
      now++;
      in_reset = reset_i;
      if (in_reset) begin
        ret_credits = RETURN_DEPTH;
        phase       = 0;
        ret_q.delete();
        credit_due_q.delete();
      end else begin
        if (ret_flit_v_o) begin
          void'(ret_q.pop_front());
          ret_credits--;
        end
        if (ret_credit_i) begin
          ret_credits++;
        end
        if (link_flit_v_i) begin
          // one pulse per cycle at most, so keep them in order
          due = now + $urandom_range(credit_delay_max_i, 0);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          credit_due_q.push_back(due);
          take_flit(link_flit_i);
        end
      end
      @(posedge clk_i);
      #1;
      link_credit_o = 1'b0;
      if (!in_reset && credit_due_q.size() != 0 && credit_due_q[0] <= now) begin
        void'(credit_due_q.pop_front());
        link_credit_o = 1'b1;
      end
      ret_flit_v_o = !in_reset && (ret_q.size() != 0) && (ret_credits > 0);
      if (ret_flit_v_o) begin
        ret_flit_o = ret_q[0];
      end
    end
  end

endmodule
